//--- hdl/trace_pkg.sv
// ==========================================================
// Trace capture package
// Sizes, APB register offsets and the history RAM init word
// shared by every block of the trace capture design
// ==========================================================

package trace_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================

    // Depth of the history RAM in samples
    localparam int n_entries = 64;

    // Width of an entry index, enough to address every entry
    localparam int idx_bits = 6;

    // Width of one captured sample, also the APB data width
    localparam int data_bits = 32;

    // Width of the APB byte address
    localparam int addr_bits = 12;

    // Word written into every entry by the power-on sweep
    localparam logic [data_bits-1:0] init_pattern = 32'hAAAA_AAAA;

    // ==========================================================
    // Register map
    // ==========================================================

    // Control register with ring_mode, write_once and clear
    localparam logic [addr_bits-1:0] reg_ctrl = 12'h000;

    // Read-only status with init_done, wrapped and the ring pointer
    localparam logic [addr_bits-1:0] reg_status = 12'h004;

    // History window, one 32-bit word per entry
    localparam logic [addr_bits-1:0] win_base = 12'h100;
    localparam logic [addr_bits-1:0] win_end = 12'h200;

endpackage

//--- hdl/trace_ram.sv
// ==========================================================
// Trace history RAM
// Simple dual-port RAM with a registered write, a two-cycle
// read and a sweep that fills every word after reset
// ==========================================================

`timescale 1ns/10ps

module trace_ram
    import trace_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wen,
    input  logic [idx_bits-1:0]  waddr,
    input  logic [data_bits-1:0] wdata,
    input  logic [idx_bits-1:0]  raddr,
    output logic [data_bits-1:0] rdata,
    output logic                 init_done
);

    logic [data_bits-1:0] mem [n_entries];

    // Write request held for one cycle before it reaches the array
    logic                 wen_q;
    logic [idx_bits-1:0]  waddr_q;
    logic [data_bits-1:0] wdata_q;

    // Sweep state
    logic [idx_bits-1:0]  init_idx;
    logic                 init_last;

    // Read address register, the first of the two read stages
    logic [idx_bits-1:0]  raddr_q;

    // ==========================================================
    // Init sweep
    // ==========================================================

    // One entry per cycle, then a single extra edge before the
    // RAM reports itself ready
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx  <= '0;
            init_last <= 1'b0;
            init_done <= 1'b0;
        end
        else if (!init_last)
        begin
            init_idx <= init_idx + 1'b1;
            if (&init_idx)
            begin
                init_last <= 1'b1;
            end
        end
        else
        begin
            init_done <= 1'b1;
        end
    end

    // Requests that arrive before the sweep has finished are dropped here
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wen_q <= 1'b0;
        end
        else
        begin
            wen_q <= wen && init_done;
        end
    end

    always_ff @(posedge clk)
    begin
        waddr_q <= waddr;
        wdata_q <= wdata;
    end

    // The sweep owns the write port until its last entry is written
    always_ff @(posedge clk)
    begin
        if (!init_last)
        begin
            mem[init_idx] <= init_pattern;
        end
        else if (wen_q)
        begin
            mem[waddr_q] <= wdata_q;
        end
    end

    // ==========================================================
    // Read path
    // ==========================================================

    // Address register then output register, so data comes two edges
    // after raddr is presented
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata   <= mem[raddr_q];
    end

endmodule

//--- hdl/trace_write_ctrl.sv
// ==========================================================
// Trace write controller
// Picks the RAM write address for each capture and keeps
// the ring pointer, the wrap flag and the write-once freeze
// ==========================================================

`timescale 1ns/10ps

module trace_write_ctrl
    import trace_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 init_done,
    input  logic                 ring_mode,
    input  logic                 write_once,
    input  logic                 clear_pulse,
    input  logic                 capture_valid,
    input  logic [data_bits-1:0] capture_data,
    input  logic [idx_bits-1:0]  capture_idx,
    output logic                 wen,
    output logic [idx_bits-1:0]  waddr,
    output logic [data_bits-1:0] wdata,
    output logic [idx_bits-1:0]  wptr,
    output logic                 wrapped
);

    // Capture handshake, ready is the RAM init_done flag
    logic accept;

    // Ring is full and write-once asks to keep the first pass
    logic frozen;

    // ==========================================================
    // Write request
    // ==========================================================

    // Samples offered before init_done are simply lost
    assign accept = capture_valid && init_done;

    // The freeze only applies in ring mode, indexed writes always land
    assign frozen = ring_mode && write_once && wrapped;

    assign wen = accept && !frozen;

    // Ring mode writes round-robin, indexed mode goes where the
    // sample says
    assign waddr = ring_mode ? wptr : capture_idx;

    // Data passes straight to the RAM, which registers it
    assign wdata = capture_data;

    // ==========================================================
    // Ring pointer and wrap flag
    // ==========================================================

    // The pointer counts written captures only, so a frozen ring
    // stays parked at zero with wrapped set
    always_ff @(posedge clk)
    begin
        if (reset || clear_pulse)
        begin
            wptr    <= '0;
            wrapped <= 1'b0;
        end
        else if (wen && ring_mode)
        begin
            wptr <= wptr + 1'b1;

            // Passing from the last entry back to zero marks a full ring
            if (&wptr)
            begin
                wrapped <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/trace_apb_regs.sv
// ==========================================================
// Trace APB slave
// Control and status registers plus the history window,
// whose reads wait on the two-cycle RAM
// ==========================================================

`timescale 1ns/10ps

module trace_apb_regs
    import trace_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [addr_bits-1:0] paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [data_bits-1:0] pwdata,
    input  logic                 init_done,
    input  logic [idx_bits-1:0]  wptr,
    input  logic                 wrapped,
    input  logic [data_bits-1:0] rdata,
    output logic [data_bits-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 ring_mode,
    output logic                 write_once,
    output logic                 clear_pulse,
    output logic [idx_bits-1:0]  raddr
);

    // Access phase of an APB transfer
    logic access;

    // Address decode
    logic sel_ctrl;
    logic sel_status;
    logic sel_win;
    logic win_rd;
    logic access_err;

    // Window entry addressed by the current transfer
    logic [idx_bits-1:0] win_idx;

    // Access cycles already spent on a window read
    logic [1:0] rd_cnt;

    // ==========================================================
    // Decode
    // ==========================================================

    assign access = psel && penable;

    assign sel_ctrl   = (paddr == reg_ctrl);
    assign sel_status = (paddr == reg_status);

    // Window words must be aligned, anything else in the range is unmapped
    assign sel_win = (paddr >= win_base) && (paddr < win_end) && (paddr[1:0] == 2'b00);

    assign win_rd = sel_win && !pwrite;

    // The window is read-only, and offsets outside the map fail
    assign access_err = (sel_win && pwrite) || !(sel_ctrl || sel_status || sel_win);

    // The base is aligned to the window size, so the low bits are the index
    assign win_idx = paddr[idx_bits+1:2];

    // Ring mode shows the newest sample first, one behind the pointer
    assign raddr = ring_mode ? (wptr - idx_bits'(1) - win_idx) : win_idx;

    // ==========================================================
    // Handshake
    // ==========================================================

    // Window reads finish in the third access cycle, everything else
    // in the first
    assign pready = access && (!win_rd || (rd_cnt == 2'd2));

    // Only meaningful together with pready
    assign pslverr = pready && access_err;

    // The RAM takes raddr at the end of the first access cycle and
    // its output register fills at the end of the second
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_cnt <= '0;
        end
        else if (pready)
        begin
            rd_cnt <= '0;
        end
        else if (access && win_rd)
        begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // ==========================================================
    // Read data
    // ==========================================================

    always_comb
    begin
        prdata = '0;
        if (sel_ctrl)
        begin
            // Clear reads back as zero
            prdata = {{(data_bits - 3){1'b0}}, 1'b0, write_once, ring_mode};
        end
        else if (sel_status)
        begin
            prdata = {{(data_bits - 14){1'b0}}, wptr, 6'b0, wrapped, init_done};
        end
        else if (win_rd)
        begin
            prdata = rdata;
        end
    end

    // ==========================================================
    // Control register
    // ==========================================================

    // Clear is a one-cycle pulse, so the pointer restarts on the edge
    // after the write completes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ring_mode   <= 1'b1;
            write_once  <= 1'b0;
            clear_pulse <= 1'b0;
        end
        else
        begin
            clear_pulse <= 1'b0;
            if (pready && pwrite && sel_ctrl)
            begin
                ring_mode   <= pwdata[0];
                write_once  <= pwdata[1];
                clear_pulse <= pwdata[2];
            end
        end
    end

endmodule

//--- hdl/trace_top.sv
// ==========================================================
// Trace capture top level
// Capture port into a 64-entry history RAM, read back
// by host software through an APB window
// ==========================================================

`timescale 1ns/10ps

module trace_top
    import trace_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    // Capture port from the design under debug
    input  logic                 capture_valid,
    input  logic [data_bits-1:0] capture_data,
    input  logic [idx_bits-1:0]  capture_idx,
    output logic                 capture_ready,

    // APB slave port
    input  logic [addr_bits-1:0] paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [data_bits-1:0] pwdata,
    output logic [data_bits-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr
);

    // RAM status
    logic                 init_done;

    // Control bits from the register block
    logic                 ring_mode;
    logic                 write_once;
    logic                 clear_pulse;

    // Ring state back to the status register
    logic [idx_bits-1:0]  wptr;
    logic                 wrapped;

    // RAM write port
    logic                 wen;
    logic [idx_bits-1:0]  waddr;
    logic [data_bits-1:0] wdata;

    // RAM read port
    logic [idx_bits-1:0]  raddr;
    logic [data_bits-1:0] rdata;

    // Captures are accepted as soon as the init sweep is over
    assign capture_ready = init_done;

    trace_write_ctrl u_write_ctrl (
        .clk,
        .reset,
        .init_done,
        .ring_mode,
        .write_once,
        .clear_pulse,
        .capture_valid,
        .capture_data,
        .capture_idx,
        .wen,
        .waddr,
        .wdata,
        .wptr,
        .wrapped
    );

    trace_ram u_ram (
        .clk,
        .reset,
        .wen,
        .waddr,
        .wdata,
        .raddr,
        .rdata,
        .init_done
    );

    trace_apb_regs u_apb_regs (
        .clk,
        .reset,
        .paddr,
        .psel,
        .penable,
        .pwrite,
        .pwdata,
        .init_done,
        .wptr,
        .wrapped,
        .rdata,
        .prdata,
        .pready,
        .pslverr,
        .ring_mode,
        .write_once,
        .clear_pulse,
        .raddr
    );

endmodule

//--- tb/trace_props.sv
// ==========================================================
// Trace capture properties
// APB handshake timing and capture-ready behavior, bound
// into the trace capture top level
// ==========================================================

`timescale 1ns/10ps

module trace_props
    import trace_pkg::*;
(
    input logic                 clk,
    input logic                 reset,
    input logic [addr_bits-1:0] paddr,
    input logic                 psel,
    input logic                 penable,
    input logic                 pwrite,
    input logic                 pready,
    input logic                 pslverr,
    input logic                 capture_ready
);

    // Failed properties so far, summed into the final report
    int fail_count = 0;

    logic setup;
    logic access;
    logic win_rd;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // Aligned reads inside the history window take the slow path
    assign win_rd = !pwrite && (paddr >= win_base) && (paddr < win_end) && (paddr[1:0] == 2'b00);

    // The slave may only complete a transfer in its access phase
    ready_in_access: assert property (@(posedge clk) disable iff (reset) pready |-> access)
    else
    begin
        fail_count++;
        $error("pready high outside an APB access phase");
    end

    // An error response is only valid together with pready
    err_with_ready: assert property (@(posedge clk) disable iff (reset) pslverr |-> pready)
    else
    begin
        fail_count++;
        $error("pslverr high without pready");
    end

    // Window reads wait for the address and output registers of the RAM
    window_latency: assert property (@(posedge clk) disable iff (reset)
        setup ##1 (access && win_rd) |-> !pready ##1 (access && !pready) ##1 (access && pready))
    else
    begin
        fail_count++;
        $error("window read did not complete in its third access cycle");
    end

    // Register reads, all writes and errors finish at once
    single_cycle: assert property (@(posedge clk) disable iff (reset)
        setup ##1 (access && !win_rd) |-> pready)
    else
    begin
        fail_count++;
        $error("APB access did not complete in its first access cycle");
    end

    // Once the init sweep is over the capture port stays open
    ready_sticky: assert property (@(posedge clk) disable iff (reset)
        capture_ready |=> capture_ready)
    else
    begin
        fail_count++;
        $error("capture_ready dropped without a reset");
    end

endmodule

bind trace_top trace_props u_props (
    .clk,
    .reset,
    .paddr,
    .psel,
    .penable,
    .pwrite,
    .pready,
    .pslverr,
    .capture_ready
);

//--- tb/trace_tb.sv
// ==========================================================
// Trace capture testbench
// Drives the capture port and APB, keeps a reference model
// of the history RAM and checks every window read against it
// ==========================================================

`timescale 1ns/10ps

module trace_tb
    import trace_pkg::*;
();

    // About 1900 cycles are used, mostly six window dumps of
    // 64 back-to-back reads at four cycles each
    localparam int max_cycles = 3000;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 capture_valid;
    logic [data_bits-1:0] capture_data;
    logic [idx_bits-1:0]  capture_idx;
    logic                 capture_ready;
    logic [addr_bits-1:0] paddr;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [data_bits-1:0] pwdata;
    logic [data_bits-1:0] prdata;
    logic                 pready;
    logic                 pslverr;

    // Reference model: physical entries, newest-first history and ring state
    logic [data_bits-1:0] model_mem [n_entries];
    logic [data_bits-1:0] newest [$];
    int                   model_ptr;
    logic                 model_wrapped;
    logic                 model_ring;
    logic                 model_once;

    int check_errors = 0;
    int cycle_count = 0;

    trace_top uut (
        .clk,
        .reset,
        .capture_valid,
        .capture_data,
        .capture_idx,
        .capture_ready,
        .paddr,
        .psel,
        .penable,
        .pwrite,
        .pwdata,
        .prdata,
        .pready,
        .pslverr
    );

    always #50 clk = ~clk;

    // ==========================================================
    // Run limit
    // ==========================================================

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= max_cycles)
        begin
            $display("Timeout: the run did not finish within %0d cycles", max_cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic compare_word(input string name, input logic [data_bits-1:0] exp,
                                input logic [data_bits-1:0] got);
        assert (got === exp)
        else
        begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // ==========================================================
    // APB master
    // ==========================================================

    // Back-to-back reads skip this, everything else ends with it
    task automatic release_bus();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // Outputs are sampled at the completing edge, before it updates them
    task automatic apb_read(input logic [addr_bits-1:0] addr, output logic [data_bits-1:0] data,
                            output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        data = prdata;
        err  = pslverr;
    endtask

    task automatic apb_write(input logic [addr_bits-1:0] addr, input logic [data_bits-1:0] data,
                             output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready)
            @(posedge clk);
        err = pslverr;
        release_bus();
    endtask

    // ==========================================================
    // Reference model
    // ==========================================================

    function automatic void model_capture(input logic [data_bits-1:0] data,
                                          input logic [idx_bits-1:0] idx);
        if (!model_ring)
            model_mem[idx] = data;
        else if (!(model_once && model_wrapped))
        begin
            model_mem[model_ptr] = data;
            newest.push_front(data);
            if (newest.size() > n_entries)
                void'(newest.pop_back());
            if (model_ptr == n_entries - 1)
                model_wrapped = 1'b1;
            model_ptr = (model_ptr + 1) % n_entries;
        end
    endfunction

    // Ring mode shows the history newest first, indexed mode the raw RAM
    function automatic logic [data_bits-1:0] expected_entry(input int i);
        logic [data_bits-1:0] exp;
        if (!model_ring)
            exp = model_mem[i];
        else if (i < newest.size())
            exp = newest[i];
        else
            exp = model_mem[(model_ptr - 1 - i + 2 * n_entries) % n_entries];
        return exp;
    endfunction

    task automatic set_control(input logic [2:0] bits);
        logic err;
        apb_write(reg_ctrl, {29'b0, bits}, err);
        compare_word("ctrl write pslverr", '0, err);
        model_ring = bits[0];
        model_once = bits[1];
        if (bits[2])
        begin
            model_ptr     = 0;
            model_wrapped = 1'b0;
            newest.delete();
        end
    endtask

    // The sample is accepted at the next rising edge if ready is high now
    task automatic offer_sample(input logic valid, input logic [data_bits-1:0] data,
                                input logic [idx_bits-1:0] idx);
        @(negedge clk);
        capture_valid = valid;
        capture_data  = data;
        capture_idx   = idx;
        if (valid && capture_ready)
            model_capture(data, idx);
    endtask

    task automatic compare_window(input string label);
        logic [data_bits-1:0] got;
        logic                 err;
        for (int i = 0; i < n_entries; i++)
        begin
            apb_read(win_base + addr_bits'(4 * i), got, err);
            compare_word($sformatf("%s prdata window[%0d]", label, i), expected_entry(i), got);
            compare_word($sformatf("%s pslverr window[%0d]", label, i), '0, err);
        end
        release_bus();
    endtask

    // Status holds init_done in bit 0, wrapped in bit 1, the pointer at 13:8
    task automatic verify_status(input string label);
        logic [data_bits-1:0] got;
        logic [data_bits-1:0] exp;
        logic                 err;
        exp = (data_bits'(model_ptr) << 8) | (data_bits'(model_wrapped) << 1) | 32'h1;
        apb_read(reg_status, got, err);
        release_bus();
        compare_word({label, " status"}, exp, got);
        compare_word({label, " status pslverr"}, '0, err);
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================

    initial
    begin
        logic [data_bits-1:0] got;
        logic                 err;
        int                   wait_cycles;
        void'($urandom(6586));
        reset         = 1'b1;
        capture_valid = 1'b0;
        capture_data  = '0;
        capture_idx   = '0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        for (int i = 0; i < n_entries; i++)
            model_mem[i] = init_pattern;
        model_ptr     = 0;
        model_wrapped = 1'b0;
        model_ring    = 1'b1;
        model_once    = 1'b0;

        // Reset and the init sweep, one entry per cycle plus one edge
        repeat (10) @(negedge clk);
        compare_word("capture_ready in reset", '0, capture_ready);
        compare_word("pready in reset", '0, pready);
        compare_word("pslverr in reset", '0, pslverr);
        reset = 1'b0;
        wait_cycles = 0;
        while (!capture_ready)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        compare_word("init sweep cycles", n_entries + 1, wait_cycles);
        compare_window("init");
        verify_status("init");

        // Ring capture with idle cycles carrying junk data
        for (int n = 0; n < 20; n++)
        begin
            if ($urandom_range(0, 2) == 0)
                offer_sample(1'b0, $urandom(), '0);
            offer_sample(1'b1, $urandom(), '0);
        end
        offer_sample(1'b0, '0, '0);
        compare_window("ring");
        verify_status("ring");

        // Ring wrap, 100 samples in total
        for (int n = 0; n < 80; n++)
            offer_sample(1'b1, $urandom(), '0);
        offer_sample(1'b0, '0, '0);
        compare_window("wrap");
        verify_status("wrap");

        // Write-once keeps the first 64 samples after the clear
        set_control(3'b111);
        for (int n = 0; n < 80; n++)
            offer_sample(1'b1, $urandom(), '0);
        offer_sample(1'b0, '0, '0);
        compare_window("write-once");
        verify_status("write-once");

        // Indexed mode at random entries
        set_control(3'b000);
        for (int n = 0; n < 40; n++)
            offer_sample(1'b1, $urandom(), idx_bits'($urandom_range(0, n_entries - 1)));
        offer_sample(1'b0, '0, '0);
        compare_window("indexed");
        verify_status("indexed");

        // Control readback and error responses
        set_control(3'b111);
        apb_read(reg_ctrl, got, err);
        release_bus();
        compare_word("ctrl readback", 32'h3, got);
        set_control(3'b000);
        apb_read(reg_ctrl, got, err);
        release_bus();
        compare_word("ctrl readback", 32'h0, got);
        apb_write(win_base + 12'd20, $urandom(), err);
        compare_word("window write pslverr", 32'h1, err);
        apb_read(12'h008, got, err);
        release_bus();
        compare_word("unmapped read pslverr", 32'h1, err);
        apb_read(win_base + 12'h002, got, err);
        release_bus();
        compare_word("misaligned read pslverr", 32'h1, err);
        verify_status("registers");
        compare_window("after errors");

        $display("Run complete: %0d check errors, %0d assertion failures",
                 check_errors, uut.u_props.fail_count);
        if (check_errors == 0 && uut.u_props.fail_count == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/trace_pkg.sv
hdl/trace_ram.sv
hdl/trace_write_ctrl.sv
hdl/trace_apb_regs.sv
hdl/trace_top.sv
tb/trace_props.sv
tb/trace_tb.sv
